// File: design/video_pkg.sv
// pixel formats and fixed color conversion constants for the video path
// shared by the converter and the 4:2:2 decimator through scoped names
`default_nettype none

package video_pkg;

  // ******************************
  // pixel formats
  // ******************************

  localparam int pixel_width     = 24;
  localparam int pixel_422_width = 16;

  // rgb view of a 4:4:4 word, r in the top byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_rgb_t;

  // ycc view of the same bits, cr on top and cb at the bottom
  typedef struct packed {
    logic [7:0] cr;
    logic [7:0] y;
    logic [7:0] cb;
  } pixel_ycc_t;

  // one 24-bit word, decoded as rgb before conversion and as ycc after
  typedef union packed {
    pixel_rgb_t rgb;
    pixel_ycc_t ycc;
  } pixel_u;

  // ******************************
  // bt.601 conversion, scaled by 256
  // ******************************

  typedef logic signed [8:0] coef_t;

  // output rows
  localparam int row_y  = 0;
  localparam int row_cr = 1;
  localparam int row_cb = 2;

  // columns are r, g, b
  localparam coef_t coef [3][3] = '{
    '{  9'sd66,   9'sd129,  9'sd25  },
    '{  9'sd112, -9'sd94,  -9'sd18  },
    '{ -9'sd38,  -9'sd74,   9'sd112 }
  };

  localparam logic [7:0] offset [3] = '{8'd16, 8'd128, 8'd128};

  // added before the >>> 8 so the shift rounds to nearest
  localparam logic signed [19:0] round_const = 20'sd128;

endpackage

`default_nettype wire

// File: design/csr_pkg.sv
// register map and bus constants of the axi4-lite control block
`default_nettype none

package csr_pkg;

  localparam int axil_addr_width = 4;

  // ******************************
  // register offsets
  // ******************************

  // read-only identity word
  localparam logic [axil_addr_width-1:0] reg_id        = 4'h0;
  // control, read-write
  localparam logic [axil_addr_width-1:0] reg_ctrl      = 4'h4;
  // output pixel counter, any write clears it
  localparam logic [axil_addr_width-1:0] reg_pix_count = 4'h8;

  localparam logic [31:0] id_value = 32'h0422_0001;

  // ctrl bit positions
  localparam int ctrl_bypass_bit   = 0;
  localparam int ctrl_cr_first_bit = 1;

  // response codes
  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

endpackage

`default_nettype wire

// File: design/csc_regs.sv
// axi4-lite slave with id, ctrl and output pixel counter registers
// ctrl bits drive the converter bypass and the starting chroma phase
`timescale 1ns/1ps
`default_nettype none

module csc_regs (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                pix_valid,
  // write address
  input  logic                                awvalid,
  input  logic [csr_pkg::axil_addr_width-1:0] awaddr,
  output logic                                awready,
  // write data
  input  logic                                wvalid,
  input  logic [31:0]                         wdata,
  output logic                                wready,
  // write response
  output logic                                bvalid,
  output logic [1:0]                          bresp,
  input  logic                                bready,
  // read address
  input  logic                                arvalid,
  input  logic [csr_pkg::axil_addr_width-1:0] araddr,
  output logic                                arready,
  // read data
  output logic                                rvalid,
  output logic [31:0]                         rdata,
  output logic [1:0]                          rresp,
  input  logic                                rready,
  // control outputs
  output logic                                csc_bypass,
  output logic                                cr_first
);

  logic                                aw_held;
  logic                                w_held;
  logic [csr_pkg::axil_addr_width-1:0] aw_addr_q;
  logic [31:0]                         w_data_q;
  logic                                aw_hs;
  logic                                w_hs;
  logic                                ar_hs;
  logic [csr_pkg::axil_addr_width-1:0] wr_addr;
  logic [31:0]                         wr_data;
  logic                                wr_commit;
  logic [1:0]                          ctrl_q;
  logic [31:0]                         ctrl_word;
  logic [31:0]                         pix_count;
  logic [31:0]                         rd_word;
  logic [1:0]                          rd_resp;

  // ******************************
  // write channel
  // ******************************

  // each channel takes one beat, then stalls until the response is taken
  assign awready = !aw_held && !bvalid;
  assign wready  = !w_held && !bvalid;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;

  // use the held beat or the one arriving now
  assign wr_addr   = aw_held ? aw_addr_q : awaddr;
  assign wr_data   = w_held ? w_data_q : wdata;
  assign wr_commit = (aw_held || aw_hs) && (w_held || w_hs);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
    end else if (wr_commit) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b1;
    end else begin
      if (aw_hs) begin
        aw_held <= 1'b1;
      end
      if (w_hs) begin
        w_held <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_addr_q <= awaddr;
    end
    if (w_hs) begin
      w_data_q <= wdata;
    end
    // unmapped offsets answer slverr, the write is dropped
    if (wr_commit) begin
      case (wr_addr)
        csr_pkg::reg_id,
        csr_pkg::reg_ctrl,
        csr_pkg::reg_pix_count: bresp <= csr_pkg::resp_okay;
        default:                bresp <= csr_pkg::resp_slverr;
      endcase
    end
  end

  // ******************************
  // ctrl and pixel counter
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q    <= '0;
      pix_count <= '0;
    end else begin
      if (wr_commit && wr_addr == csr_pkg::reg_ctrl) begin
        ctrl_q[csr_pkg::ctrl_bypass_bit]   <= wr_data[csr_pkg::ctrl_bypass_bit];
        ctrl_q[csr_pkg::ctrl_cr_first_bit] <= wr_data[csr_pkg::ctrl_cr_first_bit];
      end
      // clear has priority over a coincident count
      if (wr_commit && wr_addr == csr_pkg::reg_pix_count) begin
        pix_count <= '0;
      end else if (pix_valid) begin
        pix_count <= pix_count + 32'd1;
      end
    end
  end

  assign csc_bypass = ctrl_q[csr_pkg::ctrl_bypass_bit];
  assign cr_first   = ctrl_q[csr_pkg::ctrl_cr_first_bit];

  // ******************************
  // read channel
  // ******************************

  assign arready = !rvalid;
  assign ar_hs   = arvalid && arready;

  always_comb begin
    ctrl_word = '0;
    ctrl_word[csr_pkg::ctrl_bypass_bit]   = ctrl_q[csr_pkg::ctrl_bypass_bit];
    ctrl_word[csr_pkg::ctrl_cr_first_bit] = ctrl_q[csr_pkg::ctrl_cr_first_bit];
  end

  always_comb begin
    rd_resp = csr_pkg::resp_okay;
    case (araddr)
      csr_pkg::reg_id:        rd_word = csr_pkg::id_value;
      csr_pkg::reg_ctrl:      rd_word = ctrl_word;
      csr_pkg::reg_pix_count: rd_word = pix_count;
      default: begin
        // unmapped reads return zero
        rd_word = '0;
        rd_resp = csr_pkg::resp_slverr;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

endmodule

`default_nettype wire

// File: design/rgb_to_ycc.sv
// three-stage bt.601 rgb to crycb converter
// bypass passes the word unchanged with the same 3-cycle latency
`timescale 1ns/1ps
`default_nettype none

module rgb_to_ycc #(
  parameter int sync_width = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bypass,
  input  logic                  in_de,
  input  logic [sync_width-1:0] in_sync,
  input  video_pkg::pixel_u     in_data,
  output logic                  out_de,
  output logic [sync_width-1:0] out_sync,
  output video_pkg::pixel_u     out_data
);

  logic [7:0]               chan [3];
  logic signed [17:0]       prod [3][3];
  logic signed [19:0]       sum [3];
  logic signed [19:0]       biased [3];
  logic [7:0]               clamped [3];
  video_pkg::pixel_u        conv_word;
  logic                     de_d1;
  logic                     de_d2;
  logic [sync_width-1:0]    sync_d1;
  logic [sync_width-1:0]    sync_d2;
  video_pkg::pixel_u        data_d1;
  video_pkg::pixel_u        data_d2;

  // input columns in r, g, b order
  assign chan[0] = in_data.rgb.r;
  assign chan[1] = in_data.rgb.g;
  assign chan[2] = in_data.rgb.b;

  // ******************************
  // stage 1 and 2, products and sums
  // ******************************

  always_ff @(posedge clk) begin
    for (int row = 0; row < 3; row++) begin
      for (int col = 0; col < 3; col++) begin
        // zero-extend the channel so the multiply stays signed
        prod[row][col] <= $signed({1'b0, chan[col]}) * video_pkg::coef[row][col];
      end
      sum[row] <= prod[row][0] + prod[row][1] + prod[row][2] + video_pkg::round_const;
    end
  end

  // ******************************
  // stage 3, shift, offset, clamp
  // ******************************

  always_comb begin
    for (int row = 0; row < 3; row++) begin
      biased[row] = (sum[row] >>> 8) + $signed({12'd0, video_pkg::offset[row]});
      if (biased[row] < 0) begin
        clamped[row] = 8'd0;
      end else if (biased[row] > 20'sd255) begin
        clamped[row] = 8'd255;
      end else begin
        clamped[row] = biased[row][7:0];
      end
    end
    conv_word.ycc.cr = clamped[video_pkg::row_cr];
    conv_word.ycc.y  = clamped[video_pkg::row_y];
    conv_word.ycc.cb = clamped[video_pkg::row_cb];
  end

  // de pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_d1  <= 1'b0;
      de_d2  <= 1'b0;
      out_de <= 1'b0;
    end else begin
      de_d1  <= in_de;
      de_d2  <= de_d1;
      out_de <= de_d2;
    end
  end

  // sync and raw word ride alongside the arithmetic
  always_ff @(posedge clk) begin
    sync_d1  <= in_sync;
    sync_d2  <= sync_d1;
    out_sync <= sync_d2;
    data_d1  <= in_data;
    data_d2  <= data_d1;
    // bypassed word is already in ycc order
    out_data <= bypass ? data_d2 : conv_word;
  end

endmodule

`default_nettype wire

// File: design/chroma_444to422.sv
// 4:4:4 crycb to 4:2:2 decimator, 1-2-1 horizontal chroma filter
// output word is {cr or cb, y}, four cycles after the centre pixel
`timescale 1ns/1ps
`default_nettype none

module chroma_444to422 #(
  parameter int sync_width = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cr_first,
  input  logic                                  s444_de,
  input  logic [sync_width-1:0]                 s444_sync,
  input  video_pkg::pixel_u                     s444_data,
  output logic                                  s422_de,
  output logic [sync_width-1:0]                 s422_sync,
  output logic [video_pkg::pixel_422_width-1:0] s422_data
);

  logic                  de_d1;
  logic                  de_d2;
  logic                  de_d3;
  logic [sync_width-1:0] sync_d1;
  logic [sync_width-1:0] sync_d2;
  logic [sync_width-1:0] sync_d3;
  // d1 is the right tap, d2 the centre, d3 the left
  video_pkg::pixel_u     pix_d1;
  video_pkg::pixel_u     pix_d2;
  video_pkg::pixel_u     pix_d3;
  logic [9:0]            cr_sum;
  logic [9:0]            cb_sum;
  logic [7:0]            cr_filt;
  logic [7:0]            cb_filt;
  logic                  sel_cr;

  // ******************************
  // tap pipeline
  // ******************************

  // each data stage holds while its de is low, so the edges replicate
  // and the left tap keeps the last active pixel across blanking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_d1  <= 1'b0;
      de_d2  <= 1'b0;
      de_d3  <= 1'b0;
      pix_d1 <= '0;
      pix_d2 <= '0;
      pix_d3 <= '0;
    end else begin
      de_d1 <= s444_de;
      de_d2 <= de_d1;
      de_d3 <= de_d2;
      if (s444_de) begin
        pix_d1 <= s444_data;
      end
      if (de_d1) begin
        pix_d2 <= pix_d1;
      end
      if (de_d2) begin
        pix_d3 <= pix_d2;
      end
    end
  end

  always_ff @(posedge clk) begin
    sync_d1 <= s444_sync;
    sync_d2 <= sync_d1;
    sync_d3 <= sync_d2;
  end

  // ******************************
  // chroma filter
  // ******************************

  // outer taps plus twice the centre, /4 by truncation
  assign cr_sum = {2'd0, pix_d1.ycc.cr} + {2'd0, pix_d3.ycc.cr} + {1'd0, pix_d2.ycc.cr, 1'd0};
  assign cb_sum = {2'd0, pix_d1.ycc.cb} + {2'd0, pix_d3.ycc.cb} + {1'd0, pix_d2.ycc.cb, 1'd0};

  // lands together with the centre pixel reaching d3
  always_ff @(posedge clk) begin
    cr_filt <= cr_sum[9:2];
    cb_filt <= cb_sum[9:2];
  end

  // ******************************
  // phase and 4:2:2 output
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_cr    <= 1'b0;
      s422_de   <= 1'b0;
      s422_sync <= '0;
      s422_data <= '0;
    end else begin
      // alternate per active pixel, restart phase in blanking
      if (de_d3) begin
        sel_cr <= ~sel_cr;
      end else begin
        sel_cr <= cr_first;
      end
      s422_de   <= de_d3;
      s422_sync <= sync_d3;
      if (!de_d3) begin
        s422_data <= '0;
      end else if (sel_cr) begin
        s422_data <= {cr_filt, pix_d3.ycc.y};
      end else begin
        s422_data <= {cb_filt, pix_d3.ycc.y};
      end
    end
  end

endmodule

`default_nettype wire

// File: design/video_422_top.sv
// chroma subsampling path, register block plus converter and decimator
// video in to out is 7 cycles, register bus shares the video clock
`timescale 1ns/1ps
`default_nettype none

module video_422_top #(
  parameter int sync_width = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // axi4-lite register port
  input  logic                                  awvalid,
  input  logic [csr_pkg::axil_addr_width-1:0]   awaddr,
  output logic                                  awready,
  input  logic                                  wvalid,
  input  logic [31:0]                           wdata,
  output logic                                  wready,
  output logic                                  bvalid,
  output logic [1:0]                            bresp,
  input  logic                                  bready,
  input  logic                                  arvalid,
  input  logic [csr_pkg::axil_addr_width-1:0]   araddr,
  output logic                                  arready,
  output logic                                  rvalid,
  output logic [31:0]                           rdata,
  output logic [1:0]                            rresp,
  input  logic                                  rready,
  // 4:4:4 video in
  input  logic                                  s444_de,
  input  logic [sync_width-1:0]                 s444_sync,
  input  video_pkg::pixel_u                     s444_data,
  // 4:2:2 video out
  output logic                                  s422_de,
  output logic [sync_width-1:0]                 s422_sync,
  output logic [video_pkg::pixel_422_width-1:0] s422_data
);

  logic                  csc_bypass;
  logic                  cr_first;
  logic                  ycc_de;
  logic [sync_width-1:0] ycc_sync;
  video_pkg::pixel_u     ycc_data;

  // register block, counts pixels leaving the decimator
  csc_regs u_csc_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid  (s422_de),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wready     (wready),
    .bvalid     (bvalid),
    .bresp      (bresp),
    .bready     (bready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rresp      (rresp),
    .rready     (rready),
    .csc_bypass (csc_bypass),
    .cr_first   (cr_first)
  );

  // 3 cycles
  rgb_to_ycc #(
    .sync_width (sync_width)
  ) u_rgb_to_ycc (
    .clk      (clk),
    .rst_n    (rst_n),
    .bypass   (csc_bypass),
    .in_de    (s444_de),
    .in_sync  (s444_sync),
    .in_data  (s444_data),
    .out_de   (ycc_de),
    .out_sync (ycc_sync),
    .out_data (ycc_data)
  );

  // 4 cycles
  chroma_444to422 #(
    .sync_width (sync_width)
  ) u_chroma_444to422 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cr_first  (cr_first),
    .s444_de   (ycc_de),
    .s444_sync (ycc_sync),
    .s444_data (ycc_data),
    .s422_de   (s422_de),
    .s422_sync (s422_sync),
    .s422_data (s422_data)
  );

endmodule

`default_nettype wire

// File: bench/tb_video_422.sv
// self-checking testbench for the 4:2:2 chroma path and its register block
// random video lines against a cycle model, register traffic over axi4-lite
`timescale 1ns/1ps
`default_nettype none

module tb_video_422;

  localparam int sync_width = 2;
  // about 30 lines of up to 26 cycles plus register traffic, ten times over
  localparam int max_cycles = 20000;

  logic                    clk;
  logic                    rst_n;
  logic                    awvalid;
  logic [3:0]              awaddr;
  logic                    awready;
  logic                    wvalid;
  logic [31:0]             wdata;
  logic                    wready;
  logic                    bvalid;
  logic [1:0]              bresp;
  logic                    bready;
  logic                    arvalid;
  logic [3:0]              araddr;
  logic                    arready;
  logic                    rvalid;
  logic [31:0]             rdata;
  logic [1:0]              rresp;
  logic                    rready;
  logic                    s444_de;
  logic [sync_width-1:0]   s444_sync;
  video_pkg::pixel_u       s444_data;
  logic                    s422_de;
  logic [sync_width-1:0]   s422_sync;
  logic [15:0]             s422_data;

  // model state
  int                      cyc;
  string                   test_name;
  logic                    model_bypass;
  logic                    model_cr_first;
  int                      model_pix_count;
  logic                    in_de_h [0:max_cycles];
  logic [sync_width-1:0]   in_sync_h [0:max_cycles];
  video_pkg::pixel_u       in_ycc_h [0:max_cycles];

  video_422_top #(
    .sync_width (sync_width)
  ) u_video_422_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rready    (rready),
    .s444_de   (s444_de),
    .s444_sync (s444_sync),
    .s444_data (s444_data),
    .s422_de   (s422_de),
    .s422_sync (s422_sync),
    .s422_data (s422_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ******************************
  // checking and reference model
  // ******************************

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
      $display("Regression failed");
      $fatal(1, "value mismatch in %s", what);
    end
  endtask

  // one bt.601 row, weights scaled by 256, rounded, offset, clamped
  function automatic logic [7:0] scale_row(input int kr, input int kg, input int kb,
                                           input int ofs, input int r, input int g,
                                           input int b);
    int acc;
    logic [7:0] res;
    acc = kr * r + kg * g + kb * b + 128;
    acc = (acc >>> 8) + ofs;
    if (acc < 0) begin
      res = 8'd0;
    end else if (acc > 255) begin
      res = 8'd255;
    end else begin
      res = acc[7:0];
    end
    return res;
  endfunction

  function automatic video_pkg::pixel_u rgb2ycc(input video_pkg::pixel_u pin);
    int r;
    int g;
    int b;
    video_pkg::pixel_u pout;
    r = int'(pin.rgb.r);
    g = int'(pin.rgb.g);
    b = int'(pin.rgb.b);
    pout.ycc.y  = scale_row(66, 129, 25, 16, r, g, b);
    pout.ycc.cr = scale_row(112, -94, -18, 128, r, g, b);
    pout.ycc.cb = scale_row(-38, -74, 112, 128, r, g, b);
    return pout;
  endfunction

  // cycle counter, ends a run that never completes
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Regression failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // record inputs, then compare the output that belongs to cycle cyc-7
  always @(negedge clk) begin : monitor
    int                k;
    video_pkg::pixel_u cen;
    video_pkg::pixel_u rgt;
    logic [7:0]        chroma;
    logic [15:0]       exp_data;
    // left neighbor survives blanking, zero after reset
    static video_pkg::pixel_u left_pix = '0;
    static logic              prev_de  = 1'b0;
    static logic              phase_cr = 1'b0;
    in_de_h[cyc]   = s444_de;
    in_sync_h[cyc] = s444_sync;
    if (!s444_de) begin
      in_ycc_h[cyc] = '0;
    end else if (model_bypass) begin
      in_ycc_h[cyc] = s444_data;
    end else begin
      in_ycc_h[cyc] = rgb2ycc(s444_data);
    end
    if (cyc >= 8) begin
      k = cyc - 7;
      exp_data = '0;
      if (in_de_h[k]) begin
        cen = in_ycc_h[k];
        // right edge repeats the centre pixel
        rgt = in_de_h[k+1] ? in_ycc_h[k+1] : cen;
        phase_cr = prev_de ? !phase_cr : model_cr_first;
        if (phase_cr) begin
          chroma = 8'((int'(left_pix.ycc.cr) + 2 * int'(cen.ycc.cr) + int'(rgt.ycc.cr)) / 4);
        end else begin
          chroma = 8'((int'(left_pix.ycc.cb) + 2 * int'(cen.ycc.cb) + int'(rgt.ycc.cb)) / 4);
        end
        exp_data = {chroma, cen.ycc.y};
        left_pix = cen;
        model_pix_count = model_pix_count + 1;
      end
      prev_de = in_de_h[k];
      check_equal({test_name, "/de"}, 32'(in_de_h[k]), 32'(s422_de));
      check_equal({test_name, "/sync"}, 32'(in_sync_h[k]), 32'(s422_sync));
      check_equal({test_name, "/data"}, 32'(exp_data), 32'(s422_data));
    end
  end

  // ******************************
  // bus and video drivers
  // ******************************

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input int bdelay, output logic [1:0] resp);
    logic aw_fire;
    logic w_fire;
    @(posedge clk);
    #1;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    // handshake is decided by the values held just before the edge
    while (awvalid || wvalid) begin
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      @(posedge clk);
      #1;
      if (aw_fire) begin
        awvalid = 1'b0;
      end
      if (w_fire) begin
        wvalid = 1'b0;
      end
    end
    // response held back for a few cycles
    repeat (bdelay) begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, input int rdelay,
                           output logic [31:0] data, output logic [1:0] resp);
    logic ar_fire;
    @(posedge clk);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    while (arvalid) begin
      ar_fire = arready;
      @(posedge clk);
      #1;
      if (ar_fire) begin
        arvalid = 1'b0;
      end
    end
    repeat (rdelay) begin
      @(posedge clk);
      #1;
    end
    rready = 1'b1;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // random lines with random blanking, hsync flips each line
  task automatic send_lines(input int n_lines);
    int   len;
    int   gap;
    logic hs;
    hs = s444_sync[0];
    for (int ln = 0; ln < n_lines; ln++) begin
      len = int'($urandom_range(20, 4));
      gap = int'($urandom_range(6, 2));
      hs  = !hs;
      for (int px = 0; px < len; px++) begin
        @(posedge clk);
        #1;
        s444_de   = 1'b1;
        s444_sync = {ln == 0, hs};
        s444_data = 24'($urandom);
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
        s444_de   = 1'b0;
        s444_data = '0;
      end
    end
    // let the 7-cycle path drain before the next register access
    repeat (12) begin
      @(posedge clk);
      #1;
      s444_sync = {1'b0, hs};
    end
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin : stimulus
    logic [31:0] rd;
    logic [1:0]  resp;
    void'($urandom(32'hadca));
    cyc             = 0;
    test_name       = "reset";
    model_bypass    = 1'b0;
    model_cr_first  = 1'b0;
    model_pix_count = 0;
    rst_n     = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    s444_de   = 1'b0;
    s444_sync = '0;
    s444_data = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_equal("reset/de", 32'd0, 32'(s422_de));
    check_equal("reset/data", 32'd0, 32'(s422_data));
    axil_read(csr_pkg::reg_id, 0, rd, resp);
    check_equal("reset/id", 32'h0422_0001, rd);
    axil_read(csr_pkg::reg_ctrl, 0, rd, resp);
    check_equal("reset/ctrl", 32'd0, rd);
    axil_read(csr_pkg::reg_pix_count, 0, rd, resp);
    check_equal("reset/pix_count", 32'd0, rd);

    // converter active, cb first
    test_name = "convert";
    send_lines(10);

    test_name = "bypass";
    axil_write(csr_pkg::reg_ctrl, 32'h1, int'($urandom_range(3, 0)), resp);
    check_equal("bypass/bresp", 32'd0, 32'(resp));
    model_bypass = 1'b1;
    send_lines(10);

    // cr on the first pixel of every run, converter back on
    test_name = "phase";
    axil_write(csr_pkg::reg_ctrl, 32'h2, int'($urandom_range(3, 0)), resp);
    check_equal("phase/bresp", 32'd0, 32'(resp));
    model_bypass   = 1'b0;
    model_cr_first = 1'b1;
    send_lines(10);

    test_name = "regs";
    axil_write(csr_pkg::reg_ctrl, 32'h3, 3, resp);
    check_equal("regs/ctrl_bresp", 32'd0, 32'(resp));
    model_bypass = 1'b1;
    axil_read(csr_pkg::reg_ctrl, 4, rd, resp);
    check_equal("regs/ctrl_readback", 32'h3, rd);
    check_equal("regs/ctrl_rresp", 32'd0, 32'(resp));
    // low bits clear, so a write leaking into ctrl would show up below
    axil_write(4'hc, 32'hffff_fffc, int'($urandom_range(3, 0)), resp);
    check_equal("regs/unmapped_bresp", 32'd2, 32'(resp));
    axil_read(4'hc, int'($urandom_range(3, 0)), rd, resp);
    check_equal("regs/unmapped_rresp", 32'd2, 32'(resp));
    check_equal("regs/unmapped_rdata", 32'd0, rd);
    axil_read(csr_pkg::reg_ctrl, 0, rd, resp);
    check_equal("regs/ctrl_kept", 32'h3, rd);
    send_lines(4);
    axil_read(csr_pkg::reg_pix_count, 2, rd, resp);
    check_equal("regs/pix_count", 32'(model_pix_count), rd);
    axil_write(csr_pkg::reg_pix_count, 32'h0, 2, resp);
    model_pix_count = 0;
    axil_read(csr_pkg::reg_pix_count, 0, rd, resp);
    check_equal("regs/pix_count_cleared", 32'd0, rd);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/video_pkg.sv
design/csr_pkg.sv
design/csc_regs.sv
design/rgb_to_ycc.sv
design/chroma_444to422.sv
design/video_422_top.sv
bench/tb_video_422.sv

// File: Makefile
# Verilator build and run of the 4:2:2 chroma path testbench

VERILATOR ?= verilator
TOP       ?= tb_video_422
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
